//--- Bender.yml
package:
  name: issue_subsystem

sources:
  - files:
      - logic/issue_pkg.sv
      - logic/reg_file.sv
      - logic/decode_issue.sv
      - logic/exec_pipe.sv
      - logic/writeback_arb.sv
      - logic/issue_top.sv
  - target: test
    files:
      - verif/issue_tb.sv

//--- logic/decode_issue.sv
`timescale 1ns/10ps
// --------------------
// Decode and issue stage
// Decodes ADD, ADDI and MUL, tracks pending writes in a scoreboard
// and issues each ready instruction to the lowest-indexed ready pipe
// --------------------
module decode_issue import issue_pkg::*; #(
  parameter int NUM_PIPES = 3,
  parameter int SEQ_BITS  = 5
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [XLEN-1:0]      inst,
  input  logic [XLEN-1:0]      pc,
  input  logic [SEQ_BITS-1:0]  seq,
  input  logic                 inst_val,
  output logic                 inst_rdy,
  output logic [AREG_BITS-1:0] raddr0,
  output logic [AREG_BITS-1:0] raddr1,
  input  logic [XLEN-1:0]      rdata0,
  input  logic [XLEN-1:0]      rdata1,
  output logic [NUM_PIPES-1:0] iss_val,
  input  logic [NUM_PIPES-1:0] iss_rdy,
  output op_e                  iss_op,
  output logic [XLEN-1:0]      iss_a,
  output logic [XLEN-1:0]      iss_b,
  output logic [AREG_BITS-1:0] iss_waddr,
  output logic [SEQ_BITS-1:0]  iss_seq,
  input  logic                 wb_en,
  input  logic [AREG_BITS-1:0] wb_addr
);

  issue_state_e state;
  issue_state_e state_nxt;

  // Decode register
  logic [XLEN-1:0]     inst_q;
  logic [XLEN-1:0]     pc_q;
  logic [SEQ_BITS-1:0] seq_q;

  // Instruction fields
  logic [6:0]           opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic [AREG_BITS-1:0] rs1;
  logic [AREG_BITS-1:0] rs2;
  logic [AREG_BITS-1:0] rd;
  logic [XLEN-1:0]      imm;
  op_e                  op;
  logic                 legal;

  logic [(1<<AREG_BITS)-1:0] pending;
  logic                      full;
  logic                      hazard;
  logic                      iss_fire;
  logic                      accept;
  logic [NUM_PIPES-1:0]      pick;

  // --------------------
  // Decode
  // --------------------
  assign opcode = inst_q[6:0];
  assign rd     = inst_q[11:7];
  assign funct3 = inst_q[14:12];
  assign rs1    = inst_q[19:15];
  assign rs2    = inst_q[24:20];
  assign funct7 = inst_q[31:25];
  assign imm    = {{(XLEN-12){inst_q[31]}}, inst_q[31:20]};

  always_comb begin
    op    = OP_ADD;
    legal = 1'b0;
    if (funct3 == 3'b000) begin
      if (opcode == OPC_OPIMM) begin
        op    = OP_ADDI;
        legal = 1'b1;
      end else if (opcode == OPC_OP && funct7 == FUNCT7_MULDIV) begin
        op    = OP_MUL;
        legal = 1'b1;
      end else if (opcode == OPC_OP && funct7 == 7'b0000000) begin
        legal = 1'b1;
      end
    end
  end

  // --------------------
  // Hazards and pipe select
  // --------------------
  assign full = (state != IDLE);

  // ADDI has no rs2, those bits are immediate
  assign hazard = pending[rs1] || (op != OP_ADDI && pending[rs2]) || pending[rd];

  // Lowest set bit of the ready vector
  assign pick     = iss_rdy & (~iss_rdy + NUM_PIPES'(1));
  assign iss_val  = (full && !hazard) ? pick : '0;
  assign iss_fire = |iss_val;

  // New instruction may enter while the held one leaves
  assign inst_rdy = !full || iss_fire;
  assign accept   = inst_val && inst_rdy;

  // Operands are read in the issue cycle
  assign raddr0    = rs1;
  assign raddr1    = rs2;
  assign iss_op    = op;
  assign iss_a     = rdata0;
  assign iss_b     = (op == OP_ADDI) ? imm : rdata1;
  assign iss_waddr = rd;
  assign iss_seq   = seq_q;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (inst_val) state_nxt = ISSUE;
      end
      default: begin
        if (iss_fire) begin
          state_nxt = inst_val ? ISSUE : IDLE;
        end else begin
          state_nxt = HOLD;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      pending <= '0;
    end else begin
      state <= state_nxt;
      if (wb_en) pending[wb_addr] <= 1'b0;
      if (iss_fire && rd != '0) pending[rd] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      inst_q <= inst;
      pc_q   <= pc;
      seq_q  <= seq;
    end
  end

  // --------------------
  // Checks
  // --------------------
  a_legal: assert property (@(posedge clk) disable iff (rst) full |-> legal)
    else $error("illegal instruction %h at pc %h", inst_q, pc_q);

  a_one_issue: assert property (@(posedge clk) disable iff (rst) $onehot0(iss_val));

  // Writeback must never retire a destination that is being claimed
  a_sb_set_clr: assert property (
    @(posedge clk) disable iff (rst)
    !(iss_fire && rd != '0 && wb_en && wb_addr == rd)
  );

endmodule

//--- logic/exec_pipe.sv
`timescale 1ns/10ps
// --------------------
// Execute pipe
// Two stages, operand register then add or multiply with held result
// --------------------
module exec_pipe import issue_pkg::*; #(
  parameter int SEQ_BITS = 5
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 iss_val,
  output logic                 iss_rdy,
  input  op_e                  iss_op,
  input  logic [XLEN-1:0]      iss_a,
  input  logic [XLEN-1:0]      iss_b,
  input  logic [AREG_BITS-1:0] iss_waddr,
  input  logic [SEQ_BITS-1:0]  iss_seq,
  output logic                 res_val,
  input  logic                 res_rdy,
  output logic [XLEN-1:0]      res_data,
  output logic [AREG_BITS-1:0] res_waddr,
  output logic [SEQ_BITS-1:0]  res_seq
);

  // Stage one
  logic                 s1_val;
  op_e                  s1_op;
  logic [XLEN-1:0]      s1_a;
  logic [XLEN-1:0]      s1_b;
  logic [AREG_BITS-1:0] s1_waddr;
  logic [SEQ_BITS-1:0]  s1_seq;

  logic            s2_val;
  logic            s2_free;
  logic [XLEN-1:0] alu_out;

  assign s2_free = !s2_val || res_rdy;
  assign iss_rdy = !s1_val || s2_free;

  // Low word of the product for MUL
  always_comb begin
    case (s1_op)
      OP_MUL:  alu_out = s1_a * s1_b;
      default: alu_out = s1_a + s1_b;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_val <= 1'b0;
      s2_val <= 1'b0;
    end else begin
      if (iss_rdy) s1_val <= iss_val;
      if (s2_free) s2_val <= s1_val;
    end
  end

  always_ff @(posedge clk) begin
    if (iss_val && iss_rdy) begin
      s1_op    <= iss_op;
      s1_a     <= iss_a;
      s1_b     <= iss_b;
      s1_waddr <= iss_waddr;
      s1_seq   <= iss_seq;
    end
    if (s1_val && s2_free) begin
      res_data  <= alu_out;
      res_waddr <= s1_waddr;
      res_seq   <= s1_seq;
    end
  end

  assign res_val = s2_val;

  a_res_stable: assert property (
    @(posedge clk) disable iff (rst)
    (res_val && !res_rdy) |=> $stable(res_data)
  );

endmodule

//--- logic/issue_pkg.sv
// --------------------
// Issue subsystem shared definitions
// Widths, RISC-V encodings and enums for decode and issue
// --------------------
package issue_pkg;

  // --------------------
  // Widths
  // --------------------

  // Data word
  localparam int XLEN = 32;

  // Architectural register index
  localparam int AREG_BITS = 5;

  // --------------------
  // RISC-V encodings
  // --------------------

  // Major opcodes for register and immediate ALU ops
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;

  // funct7 of the M extension group, MUL lives here with funct3 000
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // --------------------
  // Enums
  // --------------------

  // Operations carried to the execute pipes
  typedef enum logic [1:0] {
    OP_ADD  = 2'd0,
    OP_ADDI = 2'd1,
    OP_MUL  = 2'd2
  } op_e;

  // Decode register control
  // IDLE is empty, ISSUE is a fresh instruction, HOLD is a stalled one
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    HOLD  = 2'd1,
    ISSUE = 2'd2
  } issue_state_e;

endpackage

//--- logic/issue_top.sv
`timescale 1ns/10ps
// --------------------
// Decode and issue subsystem top
// Decoder, register file, execute pipe array and writeback arbiter
// --------------------
module issue_top import issue_pkg::*; #(
  parameter int NUM_PIPES = 3,
  parameter int SEQ_BITS  = 5
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [XLEN-1:0]      inst,
  input  logic [XLEN-1:0]      pc,
  input  logic [SEQ_BITS-1:0]  seq,
  input  logic                 inst_val,
  output logic                 inst_rdy,
  output logic                 done_val,
  output logic [SEQ_BITS-1:0]  done_seq,
  output logic [AREG_BITS-1:0] done_waddr,
  output logic [XLEN-1:0]      done_data
);

  // Register file ports
  logic [AREG_BITS-1:0] raddr0;
  logic [AREG_BITS-1:0] raddr1;
  logic [XLEN-1:0]      rdata0;
  logic [XLEN-1:0]      rdata1;

  // Shared issue payload
  logic [NUM_PIPES-1:0] iss_val;
  logic [NUM_PIPES-1:0] iss_rdy;
  op_e                  iss_op;
  logic [XLEN-1:0]      iss_a;
  logic [XLEN-1:0]      iss_b;
  logic [AREG_BITS-1:0] iss_waddr;
  logic [SEQ_BITS-1:0]  iss_seq;

  // Per-pipe results
  logic [NUM_PIPES-1:0] res_val;
  logic [NUM_PIPES-1:0] res_rdy;
  logic [XLEN-1:0]      res_data  [NUM_PIPES];
  logic [AREG_BITS-1:0] res_waddr [NUM_PIPES];
  logic [SEQ_BITS-1:0]  res_seq   [NUM_PIPES];

  logic                 wb_en;
  logic [AREG_BITS-1:0] wb_addr;
  logic [XLEN-1:0]      wb_data;

  decode_issue #(
    .NUM_PIPES (NUM_PIPES),
    .SEQ_BITS  (SEQ_BITS)
  ) i_decode_issue (
    .clk       (clk),
    .rst       (rst),
    .inst      (inst),
    .pc        (pc),
    .seq       (seq),
    .inst_val  (inst_val),
    .inst_rdy  (inst_rdy),
    .raddr0    (raddr0),
    .raddr1    (raddr1),
    .rdata0    (rdata0),
    .rdata1    (rdata1),
    .iss_val   (iss_val),
    .iss_rdy   (iss_rdy),
    .iss_op    (iss_op),
    .iss_a     (iss_a),
    .iss_b     (iss_b),
    .iss_waddr (iss_waddr),
    .iss_seq   (iss_seq),
    .wb_en     (wb_en),
    .wb_addr   (wb_addr)
  );

  reg_file i_reg_file (
    .clk    (clk),
    .rst    (rst),
    .raddr0 (raddr0),
    .rdata0 (rdata0),
    .raddr1 (raddr1),
    .rdata1 (rdata1),
    .wen    (wb_en),
    .waddr  (wb_addr),
    .wdata  (wb_data)
  );

  // --------------------
  // Execute pipe array
  // --------------------
  for (genvar k = 0; k < NUM_PIPES; k++) begin : gen_pipe
    exec_pipe #(
      .SEQ_BITS (SEQ_BITS)
    ) i_exec_pipe (
      .clk       (clk),
      .rst       (rst),
      .iss_val   (iss_val[k]),
      .iss_rdy   (iss_rdy[k]),
      .iss_op    (iss_op),
      .iss_a     (iss_a),
      .iss_b     (iss_b),
      .iss_waddr (iss_waddr),
      .iss_seq   (iss_seq),
      .res_val   (res_val[k]),
      .res_rdy   (res_rdy[k]),
      .res_data  (res_data[k]),
      .res_waddr (res_waddr[k]),
      .res_seq   (res_seq[k])
    );
  end

  writeback_arb #(
    .NUM_PIPES (NUM_PIPES),
    .SEQ_BITS  (SEQ_BITS)
  ) i_writeback_arb (
    .clk        (clk),
    .rst        (rst),
    .res_val    (res_val),
    .res_rdy    (res_rdy),
    .res_data   (res_data),
    .res_waddr  (res_waddr),
    .res_seq    (res_seq),
    .wb_en      (wb_en),
    .wb_addr    (wb_addr),
    .wb_data    (wb_data),
    .done_val   (done_val),
    .done_seq   (done_seq),
    .done_waddr (done_waddr),
    .done_data  (done_data)
  );

endmodule

//--- logic/reg_file.sv
`timescale 1ns/10ps
// --------------------
// Architectural register file
// 32 x 32, two combinational reads, one write, x0 hardwired to zero
// --------------------
module reg_file import issue_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [AREG_BITS-1:0] raddr0,
  output logic [XLEN-1:0]      rdata0,
  input  logic [AREG_BITS-1:0] raddr1,
  output logic [XLEN-1:0]      rdata1,
  input  logic                 wen,
  input  logic [AREG_BITS-1:0] waddr,
  input  logic [XLEN-1:0]      wdata
);

  logic [XLEN-1:0] regs [1<<AREG_BITS];

  // Architectural state starts at zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < (1 << AREG_BITS); i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata0 = regs[raddr0];
  assign rdata1 = regs[raddr1];

  // x0 stays zero across all writebacks
  a_x0_zero: assert property (
    @(posedge clk) disable iff (rst)
    (raddr0 == '0) |-> (rdata0 == '0)
  ) else $error("x0 read back nonzero: %h", rdata0);

endmodule

//--- logic/writeback_arb.sv
`timescale 1ns/10ps
// --------------------
// Writeback arbiter
// Round-robin pick of one pipe result per cycle, drives the register
// write and a registered completion publish port
// --------------------
module writeback_arb import issue_pkg::*; #(
  parameter int NUM_PIPES = 3,
  parameter int SEQ_BITS  = 5
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [NUM_PIPES-1:0] res_val,
  output logic [NUM_PIPES-1:0] res_rdy,
  input  logic [XLEN-1:0]      res_data  [NUM_PIPES],
  input  logic [AREG_BITS-1:0] res_waddr [NUM_PIPES],
  input  logic [SEQ_BITS-1:0]  res_seq   [NUM_PIPES],
  output logic                 wb_en,
  output logic [AREG_BITS-1:0] wb_addr,
  output logic [XLEN-1:0]      wb_data,
  output logic                 done_val,
  output logic [SEQ_BITS-1:0]  done_seq,
  output logic [AREG_BITS-1:0] done_waddr,
  output logic [XLEN-1:0]      done_data
);

  localparam int PTR_BITS = (NUM_PIPES > 1) ? $clog2(NUM_PIPES) : 1;

  logic [PTR_BITS-1:0] ptr;
  logic [PTR_BITS-1:0] gnt_idx;
  logic                gnt_any;
  logic [SEQ_BITS-1:0] wb_seq;

  // Search starts at the pointer and wraps
  always_comb begin
    int idx;
    gnt_any = 1'b0;
    gnt_idx = ptr;
    for (int i = 0; i < NUM_PIPES; i++) begin
      idx = int'(ptr) + i;
      if (idx >= NUM_PIPES) idx = idx - NUM_PIPES;
      if (!gnt_any && res_val[idx]) begin
        gnt_any = 1'b1;
        gnt_idx = PTR_BITS'(idx);
      end
    end
  end

  always_comb begin
    res_rdy = '0;
    if (gnt_any) res_rdy[gnt_idx] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr      <= '0;
      wb_en    <= 1'b0;
      done_val <= 1'b0;
    end else begin
      wb_en    <= gnt_any;
      done_val <= wb_en;
      if (gnt_any) begin
        ptr <= (int'(gnt_idx) == NUM_PIPES - 1) ? '0 : gnt_idx + 1'b1;
      end
    end
  end

  // Write payload, then its completion copy one cycle later
  always_ff @(posedge clk) begin
    wb_addr    <= res_waddr[gnt_idx];
    wb_data    <= res_data[gnt_idx];
    wb_seq     <= res_seq[gnt_idx];
    done_seq   <= wb_seq;
    done_waddr <= wb_addr;
    done_data  <= wb_data;
  end

  a_one_grant: assert property (@(posedge clk) disable iff (rst) $onehot0(res_rdy));

endmodule

//--- verif/issue_golden.txt
# I inst pc seq gap   (inst and pc in hex, seq and idle gap in decimal)
# C seq waddr data    (seq and waddr in decimal, data in hex)
I 00500093 00000100 0 0
I ffd00113 00000104 1 0
I 7ff00193 00000108 2 1
I 80000213 0000010c 3 0
I 00000013 00000110 4 2
I 002082b3 00000114 5 0
I 02328333 00000118 6 0
I 02030033 0000011c 7 1
I 06400393 00000120 8 3
I 00138393 00000124 9 0
I 00900393 00000128 10 0
I 00738433 0000012c 11 0
I 00b00493 00000130 12 2
I 01600513 00000134 13 0
I 02100593 00000138 14 0
I fff00613 0000013c 15 0
I 02c607b3 00000140 16 1
I 02318833 00000144 17 0
I 030808b3 00000148 18 0
I 02120933 0000014c 19 0
C 0 1 00000005
C 1 2 fffffffd
C 2 3 000007ff
C 3 4 fffff800
C 4 0 00000000
C 5 5 00000002
C 6 6 00000ffe
C 7 0 00000000
C 8 7 00000064
C 9 7 00000065
C 10 7 00000009
C 11 8 00000012
C 12 9 0000000b
C 13 10 00000016
C 14 11 00000021
C 15 12 ffffffff
C 16 15 00000001
C 17 16 003ff001
C 18 17 017fe001
C 19 18 ffffd800

//--- verif/issue_tb.sv
`timescale 1ns/10ps
// --------------------
// Testbench for the decode and issue subsystem
// Replays golden instructions with random source gaps and checks completions
// --------------------
module issue_tb import issue_pkg::*; ();

  localparam int NUM_PIPES = 3;
  localparam int SEQ_BITS  = 5;
  localparam int NUM_SEQ   = 1 << SEQ_BITS;
  localparam int RST_CYCLES = 16;
  localparam logic [31:0] SEED = 32'hb82a2482;

  logic                 clk;
  logic                 rst;
  logic [XLEN-1:0]      inst;
  logic [XLEN-1:0]      pc;
  logic [SEQ_BITS-1:0]  seq;
  logic                 inst_val;
  logic                 inst_rdy;
  logic                 done_val;
  logic [SEQ_BITS-1:0]  done_seq;
  logic [AREG_BITS-1:0] done_waddr;
  logic [XLEN-1:0]      done_data;

  // Stimulus from the golden file, in program order
  logic [XLEN-1:0]     stim_inst [$];
  logic [XLEN-1:0]     stim_pc   [$];
  logic [SEQ_BITS-1:0] stim_seq  [$];
  int                  stim_gap  [$];

  // Expected completions, indexed by seq
  logic                 exp_valid [NUM_SEQ];
  logic [AREG_BITS-1:0] exp_waddr [NUM_SEQ];
  logic [XLEN-1:0]      exp_data  [NUM_SEQ];
  logic                 seen      [NUM_SEQ];

  int          n_exp;
  int          n_seen;
  logic        loaded;
  logic [31:0] rnd_state;

  issue_top #(
    .NUM_PIPES (NUM_PIPES),
    .SEQ_BITS  (SEQ_BITS)
  ) i_issue_top (
    .clk        (clk),
    .rst        (rst),
    .inst       (inst),
    .pc         (pc),
    .seq        (seq),
    .inst_val   (inst_val),
    .inst_rdy   (inst_rdy),
    .done_val   (done_val),
    .done_seq   (done_seq),
    .done_waddr (done_waddr),
    .done_data  (done_data)
  );

  always #5 clk = ~clk;

  // --------------------
  // Helpers
  // --------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Mostly zero, sometimes one or two idle cycles
  function automatic int random_gap();
    rnd_state = xorshift32(rnd_state);
    return (rnd_state[1:0] == 2'b00) ? 1 + int'(rnd_state[2]) : 0;
  endfunction

  task automatic load_golden();
    int              fd;
    int              code;
    int              f_seq;
    int              f_gap;
    int              f_waddr;
    logic [XLEN-1:0] f_inst;
    logic [XLEN-1:0] f_pc;
    logic [XLEN-1:0] f_data;
    byte             kind;
    string           line;
    logic            eof;
    for (int i = 0; i < NUM_SEQ; i++) begin
      exp_valid[i] = 1'b0;
      seen[i]      = 1'b0;
    end
    fd = $fopen("verif/issue_golden.txt", "r");
    if (fd == 0) abort_run("Cannot open the golden file verif/issue_golden.txt");
    eof = 1'b0;
    while (!eof) begin
      code = $fscanf(fd, " %c", kind);
      if (code != 1) begin
        eof = 1'b1;
      end else if (kind == "#") begin
        code = $fgets(line, fd);
      end else if (kind == "I") begin
        code = $fscanf(fd, "%h %h %d %d", f_inst, f_pc, f_seq, f_gap);
        if (code != 4) abort_run("Golden file has a malformed instruction line");
        stim_inst.push_back(f_inst);
        stim_pc.push_back(f_pc);
        stim_seq.push_back(SEQ_BITS'(f_seq));
        stim_gap.push_back(f_gap);
      end else if (kind == "C") begin
        code = $fscanf(fd, "%d %d %h", f_seq, f_waddr, f_data);
        if (code != 3) abort_run("Golden file has a malformed completion line");
        else if (f_seq < 0 || f_seq >= NUM_SEQ || exp_valid[f_seq])
          abort_run($sformatf("Golden file lists seq %0d twice or out of range", f_seq));
        exp_valid[f_seq] = 1'b1;
        exp_waddr[f_seq] = AREG_BITS'(f_waddr);
        exp_data[f_seq]  = f_data;
        n_exp++;
      end else begin
        abort_run($sformatf("Golden file has an unknown line kind '%c'", kind));
      end
    end
    $fclose(fd);
    if (n_exp != stim_inst.size())
      abort_run("Golden file lists a different number of instructions and completions");
  endtask

  // Leaves the source idle, then holds one instruction until the handshake
  task automatic send_inst(input int idx);
    int   gap;
    logic rdy;
    gap = stim_gap[idx] + random_gap();
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    inst     = stim_inst[idx];
    pc       = stim_pc[idx];
    seq      = stim_seq[idx];
    inst_val = 1'b1;
    rdy      = 1'b0;
    while (!rdy) begin
      @(negedge clk);
      rdy = inst_rdy;
      @(posedge clk);
    end
    #1;
    inst_val = 1'b0;
  endtask

  // --------------------
  // Completion check
  // --------------------
  task automatic compare_done(input logic [SEQ_BITS-1:0] s, input logic [AREG_BITS-1:0] w,
                              input logic [XLEN-1:0] d);
    if (!exp_valid[s]) begin
      abort_run($sformatf("Completion for seq %0d at %0t is not in the golden file", s, $time));
    end else if (seen[s]) begin
      abort_run($sformatf("Seq %0d completed a second time at %0t", s, $time));
    end else if (w !== exp_waddr[s] || d !== exp_data[s]) begin
      abort_run($sformatf("Mismatch at %0t: seq %0d wrote x%0d = %h, expected x%0d = %h",
                          $time, s, w, d, exp_waddr[s], exp_data[s]));
    end else begin
      seen[s] = 1'b1;
      n_seen++;
    end
  endtask

  // Completions are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    if (!rst && done_val) compare_done(done_seq, done_waddr, done_data);
  end

  // Watchdog
  initial begin
    wait (loaded);
    repeat (RST_CYCLES + 40 * stim_inst.size()) @(posedge clk);
    abort_run($sformatf("Run timed out with %0d of %0d completions seen", n_seen, n_exp));
  end

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    inst      = '0;
    pc        = '0;
    seq       = '0;
    inst_val  = 1'b0;
    n_exp     = 0;
    n_seen    = 0;
    loaded    = 1'b0;
    rnd_state = SEED;
    load_golden();
    loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < stim_inst.size(); i++) begin
      send_inst(i);
    end
    while (n_seen < n_exp) @(posedge clk);
    // A few quiet cycles to catch stray completions
    repeat (10) @(negedge clk);
    // Drained subsystem takes input again
    if (inst_rdy !== 1'b1) begin
      abort_run("Input is not ready after all completions were seen");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

//--- vlog.f
logic/issue_pkg.sv
logic/reg_file.sv
logic/decode_issue.sv
logic/exec_pipe.sv
logic/writeback_arb.sv
logic/issue_top.sv
verif/issue_tb.sv
